/* verilog/mgmt_consts.svh */
// management port constants
`ifndef MGMT_CONSTS_SVH
`define MGMT_CONSTS_SVH

//////////////////////
// module ids
`define MGMT_MID_BANK0          7'd0    // on-chip bank 0
`define MGMT_MID_BANK1          7'd8    // on-chip bank 1
`define MGMT_MID_EXT            7'd122  // external target port

//////////////////////
// command type codes
`define MGMT_TYPE_WR            2'b01
`define MGMT_TYPE_RD            2'b10
`define MGMT_TYPE_ACK           2'b11

//////////////////////
// sizing
`define MGMT_BANK_DEPTH         16      // words per bank
`define MGMT_RSP_TIMEOUT        16      // cycles to wait on the external target

`endif

/* verilog/mgmt_pkg.sv */
// management port types
package mgmt_pkg;

        typedef logic [6:0]  mid_t;
        typedef logic [18:0] maddr_t;
        typedef logic [31:0] mdata_t;
        typedef logic [1:0]  cmd_type_t;

        // 64-bit command word, also used for acks
        typedef struct packed {
                cmd_type_t  cmd_type;   // [63:62]
                logic       addr_fixed; // [61]
                logic [1:0] rsvd;       // [60:59]
                logic       err;        // [58] timeout flag in acks
                mid_t       mid;        // [57:51]
                maddr_t     maddr;      // [50:32]
                mdata_t     data;       // [31:0]
        } mgmt_cmd_t;

        typedef struct packed {
                logic       wr;
                logic       rd;
                maddr_t     maddr;
                logic       addr_fixed;
                mdata_t     wdata;
        } mgmt_req_t;

        typedef struct packed {
                logic       wr;         // one-cycle response strobe
                maddr_t     maddr;
                logic       addr_fixed;
                mdata_t     rdata;
        } mgmt_rsp_t;

        typedef enum logic {ST_IDLE, ST_WAIT_RSP} disp_state_t;

endpackage

/* verilog/register_bank.sv */
// on-chip register bank
`timescale 1ns/1ps
`include "mgmt_consts.svh"

module register_bank (
        input  logic                i_clk,
        input  logic                i_rst_n,
        input  mgmt_pkg::mgmt_req_t i_req,
        output mgmt_pkg::mgmt_rsp_t o_rsp
);

        localparam int AW = $clog2(`MGMT_BANK_DEPTH);

        mgmt_pkg::mdata_t mem [`MGMT_BANK_DEPTH];
        logic [AW-1:0]    idx;

        assign idx = i_req.maddr[AW-1:0]; // upper maddr bits ignored

        //////////////////////
        // storage
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        for (int i = 0; i < `MGMT_BANK_DEPTH; i++) begin
                                mem[i] <= '0;
                        end
                end else if (i_req.wr) begin
                        mem[idx] <= i_req.wdata;
                end
        end

        //////////////////////
        // read response
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_rsp <= '0;
                end else begin
                        o_rsp.wr <= i_req.rd; // strobe only on reads
                        if (i_req.rd) begin
                                o_rsp.maddr      <= i_req.maddr;
                                o_rsp.addr_fixed <= i_req.addr_fixed;
                                o_rsp.rdata      <= mem[idx];
                        end
                end
        end

endmodule

/* verilog/response_timer.sv */
// external response timer
`timescale 1ns/1ps
`include "mgmt_consts.svh"

module response_timer (
        input  logic i_clk,
        input  logic i_rst_n,
        input  logic i_start,
        input  logic i_stop,
        output logic o_expired
);

        localparam int CNT_W = $clog2(`MGMT_RSP_TIMEOUT) + 1;

        logic [CNT_W-1:0] cnt;
        logic [CNT_W-1:0] cnt_nxt;
        logic             armed;

        assign cnt_nxt = cnt + 1'b1;

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        cnt       <= '0;
                        armed     <= 1'b0;
                        o_expired <= 1'b0;
                end else begin
                        o_expired <= 1'b0;
                        if (i_start) begin
                                cnt   <= '0;
                                armed <= 1'b1;
                        end else if (i_stop) begin
                                armed <= 1'b0; // answered in time
                        end else if (armed) begin
                                cnt <= cnt_nxt;
                                if (cnt_nxt == CNT_W'(`MGMT_RSP_TIMEOUT)) begin
                                        o_expired <= 1'b1;
                                        armed     <= 1'b0;
                                end
                        end
                end
        end

endmodule

/* verilog/command_dispatch_fsm.sv */
// command dispatcher
`timescale 1ns/1ps
`include "mgmt_consts.svh"

module command_dispatch_fsm (
        input  logic                i_clk,
        input  logic                i_rst_n,
        input  logic                i_cmd_wr,
        input  mgmt_pkg::mgmt_cmd_t i_cmd,
        output logic                o_cmd_ready,
        output mgmt_pkg::mgmt_req_t o_bank0_req,
        output mgmt_pkg::mgmt_req_t o_bank1_req,
        output mgmt_pkg::mgmt_req_t o_ext_req,
        input  mgmt_pkg::mgmt_rsp_t i_ext_rsp,
        output mgmt_pkg::mgmt_rsp_t o_ext_rsp_gated,
        output logic                o_timer_start,
        output logic                o_timer_stop,
        input  logic                i_timer_expired,
        output mgmt_pkg::mgmt_rsp_t o_timeout_rsp
);

        localparam logic [1:0] BANK_RD_WAIT = 2'd2; // bank rsp stage + ack stage

        mgmt_pkg::disp_state_t state;
        mgmt_pkg::mgmt_cmd_t   cmd_q;
        mgmt_pkg::mgmt_req_t   req_next;
        logic                  cmd_vld;
        logic                  cmd_take;
        logic                  cmd_known;
        logic                  q_wr;
        logic                  q_rd;
        logic                  q_ext;
        logic                  wait_ext;
        logic [1:0]            lat_cnt;
        logic                  req_busy;
        logic                  rsp_gate;

        //////////////////////
        // command intake
        assign cmd_known = ((i_cmd.mid == `MGMT_MID_BANK0) ||
                            (i_cmd.mid == `MGMT_MID_BANK1) ||
                            (i_cmd.mid == `MGMT_MID_EXT)) &&
                           ((i_cmd.cmd_type == `MGMT_TYPE_WR) ||
                            (i_cmd.cmd_type == `MGMT_TYPE_RD));
        assign cmd_take  = i_cmd_wr && o_cmd_ready;
        assign req_busy  = o_bank0_req.wr || o_bank0_req.rd || o_bank1_req.wr ||
                           o_bank1_req.rd || o_ext_req.wr || o_ext_req.rd;
        assign o_cmd_ready = (state == mgmt_pkg::ST_IDLE) && !cmd_vld && !req_busy;

        always_ff @(posedge i_clk) begin
                if (cmd_take) begin
                        cmd_q <= i_cmd;
                end
        end

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        cmd_vld <= 1'b0;
                end else begin
                        cmd_vld <= cmd_take && cmd_known; // unknown mid dropped here
                end
        end

        assign q_wr  = (cmd_q.cmd_type == `MGMT_TYPE_WR);
        assign q_rd  = (cmd_q.cmd_type == `MGMT_TYPE_RD);
        assign q_ext = (cmd_q.mid == `MGMT_MID_EXT);
        assign req_next = '{wr: q_wr, rd: q_rd, maddr: cmd_q.maddr,
                            addr_fixed: cmd_q.addr_fixed, wdata: cmd_q.data};

        //////////////////////
        // request strobes
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_bank0_req <= '0;
                        o_bank1_req <= '0;
                        o_ext_req   <= '0;
                end else begin
                        o_bank0_req <= '0;
                        o_bank1_req <= '0;
                        o_ext_req   <= '0;
                        if (cmd_vld) begin
                                case (cmd_q.mid)
                                        `MGMT_MID_BANK0: o_bank0_req <= req_next;
                                        `MGMT_MID_BANK1: o_bank1_req <= req_next;
                                        default:         o_ext_req   <= req_next;
                                endcase
                        end
                end
        end

        //////////////////////
        // read wait
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        state    <= mgmt_pkg::ST_IDLE;
                        wait_ext <= 1'b0;
                        lat_cnt  <= '0;
                end else begin
                        case (state)
                                mgmt_pkg::ST_IDLE: begin
                                        if (cmd_vld && q_rd) begin
                                                state    <= mgmt_pkg::ST_WAIT_RSP;
                                                wait_ext <= q_ext;
                                                lat_cnt  <= BANK_RD_WAIT;
                                        end
                                end
                                mgmt_pkg::ST_WAIT_RSP: begin
                                        if (wait_ext) begin
                                                if (o_ext_rsp_gated.wr || i_timer_expired) begin
                                                        state <= mgmt_pkg::ST_IDLE;
                                                end
                                        end else if (lat_cnt == 2'd0) begin
                                                state <= mgmt_pkg::ST_IDLE; // bank ack is out
                                        end else begin
                                                lat_cnt <= lat_cnt - 2'd1;
                                        end
                                end
                                default: state <= mgmt_pkg::ST_IDLE;
                        endcase
                end
        end

        // only an outstanding external read lets the response through
        assign rsp_gate        = (state == mgmt_pkg::ST_WAIT_RSP) && wait_ext;
        assign o_ext_rsp_gated = rsp_gate ? i_ext_rsp : '0;
        assign o_timer_start   = cmd_vld && q_rd && q_ext;
        assign o_timer_stop    = o_ext_rsp_gated.wr;
        assign o_timeout_rsp   = '{wr: rsp_gate && i_timer_expired, maddr: cmd_q.maddr,
                                   addr_fixed: cmd_q.addr_fixed, rdata: '0};

endmodule

/* verilog/commandack_generate.sv */
// command ack merge
`timescale 1ns/1ps
`include "mgmt_consts.svh"

module commandack_generate (
        input  logic                i_clk,
        input  logic                i_rst_n,
        input  mgmt_pkg::mgmt_rsp_t i_bank0_rsp,
        input  mgmt_pkg::mgmt_rsp_t i_bank1_rsp,
        input  mgmt_pkg::mgmt_rsp_t i_ext_rsp,
        input  mgmt_pkg::mgmt_rsp_t i_timeout_rsp,
        output logic                o_ack_wr,
        output mgmt_pkg::mgmt_cmd_t o_ack
);

        // pack one target response into the ack layout
        function automatic mgmt_pkg::mgmt_cmd_t make_ack(input mgmt_pkg::mgmt_rsp_t rsp,
                                                         input mgmt_pkg::mid_t mid,
                                                         input logic err);
                mgmt_pkg::mgmt_cmd_t ack;
                ack            = '0;
                ack.cmd_type   = `MGMT_TYPE_ACK;
                ack.addr_fixed = rsp.addr_fixed;
                ack.err        = err;
                ack.mid        = mid;
                ack.maddr      = rsp.maddr;
                ack.data       = rsp.rdata;
                return ack;
        endfunction

        //////////////////////
        // priority merge
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_ack_wr <= 1'b0;
                        o_ack    <= '0;
                end else begin
                        o_ack_wr <= i_bank0_rsp.wr || i_bank1_rsp.wr ||
                                    i_ext_rsp.wr || i_timeout_rsp.wr;
                        if (i_bank0_rsp.wr) begin
                                o_ack <= make_ack(i_bank0_rsp, `MGMT_MID_BANK0, 1'b0);
                        end else if (i_bank1_rsp.wr) begin
                                o_ack <= make_ack(i_bank1_rsp, `MGMT_MID_BANK1, 1'b0);
                        end else if (i_ext_rsp.wr) begin
                                o_ack <= make_ack(i_ext_rsp, `MGMT_MID_EXT, 1'b0);
                        end else if (i_timeout_rsp.wr) begin
                                o_ack <= make_ack(i_timeout_rsp, `MGMT_MID_EXT, 1'b1); // no answer
                        end else begin
                                o_ack <= '0;
                        end
                end
        end

endmodule

/* verilog/mgmt_top.sv */
// management port top level
`timescale 1ns/1ps

module mgmt_top (
        input  logic                i_clk,
        input  logic                i_rst_n,
        input  logic                i_cmd_wr,
        input  mgmt_pkg::mgmt_cmd_t i_cmd,
        output logic                o_cmd_ready,
        output mgmt_pkg::mgmt_req_t o_ext_req,
        input  mgmt_pkg::mgmt_rsp_t i_ext_rsp,
        output logic                o_ack_wr,
        output mgmt_pkg::mgmt_cmd_t o_ack
);

        mgmt_pkg::mgmt_req_t bank0_req;
        mgmt_pkg::mgmt_req_t bank1_req;
        mgmt_pkg::mgmt_rsp_t bank0_rsp;
        mgmt_pkg::mgmt_rsp_t bank1_rsp;
        mgmt_pkg::mgmt_rsp_t ext_rsp_gated;
        mgmt_pkg::mgmt_rsp_t timeout_rsp;
        logic                timer_start;
        logic                timer_stop;
        logic                timer_expired;

        command_dispatch_fsm u_dispatch (
                .i_clk           (i_clk),
                .i_rst_n         (i_rst_n),
                .i_cmd_wr        (i_cmd_wr),
                .i_cmd           (i_cmd),
                .o_cmd_ready     (o_cmd_ready),
                .o_bank0_req     (bank0_req),
                .o_bank1_req     (bank1_req),
                .o_ext_req       (o_ext_req),
                .i_ext_rsp       (i_ext_rsp),
                .o_ext_rsp_gated (ext_rsp_gated),
                .o_timer_start   (timer_start),
                .o_timer_stop    (timer_stop),
                .i_timer_expired (timer_expired),
                .o_timeout_rsp   (timeout_rsp)
        );

        response_timer u_timer (
                .i_clk     (i_clk),
                .i_rst_n   (i_rst_n),
                .i_start   (timer_start),
                .i_stop    (timer_stop),
                .o_expired (timer_expired)
        );

        register_bank u_bank0 (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_req(bank0_req), .o_rsp(bank0_rsp));
        register_bank u_bank1 (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_req(bank1_req), .o_rsp(bank1_rsp));

        commandack_generate u_ack (
                .i_clk         (i_clk),
                .i_rst_n       (i_rst_n),
                .i_bank0_rsp   (bank0_rsp),
                .i_bank1_rsp   (bank1_rsp),
                .i_ext_rsp     (ext_rsp_gated),
                .i_timeout_rsp (timeout_rsp),
                .o_ack_wr      (o_ack_wr),
                .o_ack         (o_ack)
        );

endmodule

/* verification/mgmt_chk.sv */
// management port assertions
`timescale 1ns/1ps

module mgmt_chk (
        input logic                i_clk,
        input logic                i_rst_n,
        input logic                i_cmd_ready,
        input mgmt_pkg::mgmt_req_t i_ext_req,
        input logic                i_ack_wr,
        input mgmt_pkg::mgmt_cmd_t i_ack
);

        logic ext_pending; // external read issued, ack not seen yet

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        ext_pending <= 1'b0;
                end else if (i_ext_req.rd) begin
                        ext_pending <= 1'b1;
                end else if (i_ack_wr) begin
                        ext_pending <= 1'b0;
                end
        end

        a_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                i_ack_wr |=> !i_ack_wr)
                else $error("o_ack_wr high for more than one cycle");

        a_ack_idle_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                !i_ack_wr |-> (i_ack == '0))
                else $error("o_ack not zero while o_ack_wr is low");

        a_ready_ext: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                (ext_pending && !i_ack_wr) |-> !i_cmd_ready)
                else $error("o_cmd_ready high during an external read");

endmodule

bind mgmt_top mgmt_chk u_chk (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_ready (o_cmd_ready),
        .i_ext_req   (o_ext_req),
        .i_ack_wr    (o_ack_wr),
        .i_ack       (o_ack)
);

/* verification/mgmt_tb.sv */
// management port testbench
`timescale 1ns/1ps
`include "mgmt_consts.svh"

module mgmt_tb;

        typedef struct packed {
                mgmt_pkg::mgmt_cmd_t cmd;
                logic [7:0]          ext_delay; // above the timeout means no answer
                logic                exp_ack;
                logic                exp_err;
                mgmt_pkg::mdata_t    exp_data;
                logic [3:0]          exp_lat;   // 0 skips the latency check
        } row_t;

        localparam mgmt_pkg::cmd_type_t WR  = `MGMT_TYPE_WR;
        localparam mgmt_pkg::cmd_type_t RD  = `MGMT_TYPE_RD;
        localparam mgmt_pkg::mid_t      B0  = `MGMT_MID_BANK0;
        localparam mgmt_pkg::mid_t      B1  = `MGMT_MID_BANK1;
        localparam mgmt_pkg::mid_t      EXT = `MGMT_MID_EXT;
        localparam mgmt_pkg::mid_t      UNK = 7'd5; // no target behind it

        logic                i_clk;
        logic                i_rst_n;
        logic                i_cmd_wr;
        mgmt_pkg::mgmt_cmd_t i_cmd;
        logic                o_cmd_ready;
        mgmt_pkg::mgmt_req_t o_ext_req;
        mgmt_pkg::mgmt_rsp_t i_ext_rsp;
        logic                o_ack_wr;
        mgmt_pkg::mgmt_cmd_t o_ack;

        row_t                rows [$];
        mgmt_pkg::mdata_t    shadow [2][16];
        mgmt_pkg::mgmt_req_t ext_wr_seen;
        int                  ext_delay;
        int                  tests;
        int                  errors;
        integer              seed;

        mgmt_top UUT (.*);

        initial i_clk = 1'b0;
        always #2 i_clk = ~i_clk;

        function automatic mgmt_pkg::mgmt_cmd_t to_cmd(input mgmt_pkg::cmd_type_t t,
                                                       input logic af, input mgmt_pkg::mid_t mid,
                                                       input mgmt_pkg::maddr_t maddr,
                                                       input mgmt_pkg::mdata_t data);
                mgmt_pkg::mgmt_cmd_t c;
                c            = '0;
                c.cmd_type   = t;
                c.addr_fixed = af;
                c.mid        = mid;
                c.maddr      = maddr;
                c.data       = data;
                return c;
        endfunction

        task automatic add_row(input mgmt_pkg::cmd_type_t t, input mgmt_pkg::mid_t mid,
                               input mgmt_pkg::maddr_t maddr, input logic af,
                               input mgmt_pkg::mdata_t data, input logic [7:0] dly,
                               input logic ack, input logic err,
                               input mgmt_pkg::mdata_t exp, input logic [3:0] lat);
                row_t r;
                r.cmd       = to_cmd(t, af, mid, maddr, data);
                r.ext_delay = dly;
                r.exp_ack   = ack;
                r.exp_err   = err;
                r.exp_data  = exp;
                r.exp_lat   = lat;
                rows.push_back(r);
        endtask

        // send one command and watch for its ack
        task automatic run_cmd(input mgmt_pkg::mgmt_cmd_t cmd, input logic exp_ack,
                               input logic exp_err, input mgmt_pkg::mdata_t exp_data,
                               input logic [3:0] exp_lat, output bit ok);
                mgmt_pkg::mgmt_cmd_t exp;
                int                  n;
                ok = 1'b1;
                n  = 0;
                @(negedge i_clk);
                while (!o_cmd_ready && n < 50) begin
                        @(negedge i_clk);
                        n++;
                end
                if (!o_cmd_ready) begin
                        $display("o_cmd_ready stayed low, command not sent");
                        ok = 1'b0;
                        return;
                end
                @(posedge i_clk);
                i_cmd_wr <= 1'b1;
                i_cmd    <= cmd;
                @(posedge i_clk);               // command taken here
                i_cmd_wr <= 1'b0;
                n = 0;
                do begin
                        @(posedge i_clk);
                        n++;
                        @(negedge i_clk);
                end while (!o_ack_wr && n < 40);
                if (o_ack_wr !== exp_ack) begin
                        $display("%s", exp_ack ? "no ack within 40 cycles" :
                                                 "ack for a command that takes none");
                        ok = 1'b0;
                end else if (exp_ack) begin
                        exp = to_cmd(`MGMT_TYPE_ACK, cmd.addr_fixed, cmd.mid, cmd.maddr,
                                     exp_data);
                        exp.err = exp_err;
                        if (o_ack !== exp) begin
                                $display("[FAIL] o_ack exp 0x%016h got 0x%016h", exp, o_ack);
                                ok = 1'b0;
                        end
                        if (exp_lat != 0 && n != exp_lat) begin
                                $display("[FAIL] ack latency exp 0x%0h got 0x%0h", exp_lat, n);
                                ok = 1'b0;
                        end
                end
        endtask

        task automatic note_result(input string what, input bit ok);
                tests++;
                if (!ok) begin
                        errors++;
                end
                $display("test %0d %s: %s", tests, what, ok ? "ok" : "failed");
        endtask

        ////////////////////
        // external target model
        always begin : ext_target
                mgmt_pkg::mgmt_req_t req;
                @(negedge i_clk);
                if (o_ext_req.wr) begin
                        ext_wr_seen = o_ext_req; // last write seen on the port
                end
                if (o_ext_req.rd && ext_delay <= `MGMT_RSP_TIMEOUT) begin
                        req = o_ext_req;
                        repeat (ext_delay) @(posedge i_clk);
                        i_ext_rsp <= '{wr: 1'b1, maddr: req.maddr, addr_fixed: req.addr_fixed,
                                       rdata: {13'd0, req.maddr} ^ 32'h5a5a_0000};
                        @(posedge i_clk);
                        i_ext_rsp <= '0;
                end
        end

        ////////////////////
        // main sequence
        initial begin
                row_t                r;
                bit                  ok;
                logic [31:0]         rnd;
                logic                bank;
                mgmt_pkg::mgmt_req_t exp_req;
                i_rst_n     = 1'b0;
                i_cmd_wr    = 1'b0;
                i_cmd       = '0;
                i_ext_rsp   = '0;
                ext_wr_seen = '0;
                ext_delay   = 1;
                tests       = 0;
                errors      = 0;
                seed        = 32'hdb1a_72bd;
                foreach (shadow[b, a]) shadow[b][a] = '0;

                add_row(WR, B0,  19'h0_0003, 0, 32'h1111_aaaa, 1, 0, 0, 32'h0, 0);
                add_row(WR, B1,  19'h4_0005, 1, 32'h2222_bbbb, 1, 0, 0, 32'h0, 0);
                add_row(RD, B0,  19'h0_0003, 0, 32'h0, 1, 1, 0, 32'h1111_aaaa, 3);
                add_row(RD, B1,  19'h4_0005, 1, 32'h0, 1, 1, 0, 32'h2222_bbbb, 3);
                add_row(RD, EXT, 19'h0_1234, 0, 32'h0, 3, 1, 0, 32'h5a5a_1234, 0);
                add_row(RD, EXT, 19'h7_0abc, 1, 32'h0, 12, 1, 0, 32'h5a5d_0abc, 0);
                add_row(RD, EXT, 19'h0_0042, 1, 32'h0, 99, 1, 1, 32'h0, 0);
                add_row(WR, EXT, 19'h0_0010, 0, 32'hdead_beef, 1, 0, 0, 32'h0, 0);
                add_row(WR, UNK, 19'h0_0003, 0, 32'hffff_0000, 1, 0, 0, 32'h0, 0);
                add_row(RD, UNK, 19'h0_0003, 0, 32'h0, 1, 0, 0, 32'h0, 0);
                add_row(RD, B0,  19'h0_0003, 0, 32'h0, 1, 1, 0, 32'h1111_aaaa, 3);

                repeat (5) @(posedge i_clk);
                i_rst_n <= 1'b1;
                @(negedge i_clk);
                ok = o_cmd_ready && !o_ack_wr && !o_ext_req.wr && !o_ext_req.rd;
                if (!ok) begin
                        $display("[FAIL] ready/ack_wr/ext wr/ext rd after reset: %h %h %h %h",
                                 o_cmd_ready, o_ack_wr, o_ext_req.wr, o_ext_req.rd);
                end
                note_result("reset state", ok);

                foreach (rows[i]) begin
                        r           = rows[i];
                        ext_delay   = r.ext_delay;
                        ext_wr_seen = '0;
                        run_cmd(r.cmd, r.exp_ack, r.exp_err, r.exp_data, r.exp_lat, ok);
                        if (r.cmd.cmd_type == WR && r.cmd.mid == EXT) begin
                                exp_req = '{wr: 1'b1, rd: 1'b0, maddr: r.cmd.maddr,
                                            addr_fixed: r.cmd.addr_fixed, wdata: r.cmd.data};
                                if (ext_wr_seen !== exp_req) begin
                                        $display("[FAIL] o_ext_req exp 0x%h got 0x%h",
                                                 exp_req, ext_wr_seen);
                                        ok = 1'b0;
                                end
                        end
                        if (r.cmd.cmd_type == WR && (r.cmd.mid == B0 || r.cmd.mid == B1)) begin
                                shadow[r.cmd.mid == B1][r.cmd.maddr[3:0]] = r.cmd.data;
                        end
                        note_result($sformatf("row %0d mid %0d", i, r.cmd.mid), ok);
                end

                // random bank traffic against the shadow memory
                for (int k = 0; k < 24; k++) begin
                        rnd  = $random(seed);
                        bank = rnd[0];
                        r.cmd = to_cmd(rnd[21] ? WR : RD, rnd[20], bank ? B1 : B0, rnd[19:1],
                                       $random(seed));
                        run_cmd(r.cmd, !rnd[21], 1'b0, shadow[bank][rnd[4:1]], 3, ok);
                        if (rnd[21]) begin
                                shadow[bank][rnd[4:1]] = r.cmd.data;
                        end
                        note_result($sformatf("random %0d", k), ok);
                end

                $display("%0d tests, %0d failed", tests, errors);
                if (errors == 0) begin
                        $display(">>> PASS");
                end else begin
                        $display(">>> FAIL");
                end
                $finish;
        end

endmodule

/* compile.f */
+incdir+verilog
verilog/mgmt_pkg.sv
verilog/register_bank.sv
verilog/response_timer.sv
verilog/command_dispatch_fsm.sv
verilog/commandack_generate.sv
verilog/mgmt_top.sv
verification/mgmt_chk.sv
verification/mgmt_tb.sv
